/* list.f */
source/rv_core_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_tracelog.sv
source/rv_trace_core.sv
test/tb_rv_trace_core.sv

/* run.sh */
#!/bin/sh
# Build and run the trace core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_trace_core -Mdir obj_dir -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_rv_trace_core
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

/* source/rv_core_pkg.sv */
// --------------------
// Shared types of the RV32I trace core. All words are 32 bits.
// The register index is always 5 bits, even for a 16-register core.
// --------------------

package rv_core_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] xlen_t;     // Data or address word
    typedef logic [4:0]  reg_idx_t;  // Register index
    typedef logic [31:0] stamp_t;    // Cycles since reset
    typedef logic [15:0] delay_t;    // Cycles since previous record, saturating

    localparam xlen_t RESET_PC = '0;

    // Major opcodes that are supported
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B,  // LUI, immediate goes straight through
        ALU_LINK     // JAL, return address pc+4
    } alu_op_e;

    // --------------------
    // Stage payloads
    // --------------------
    typedef struct packed {
        xlen_t    pc;
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        logic     use_imm;  // Operand b from imm instead of rs2
        logic     wr_en;
        logic     illegal;
    } dec_op_t;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        logic     wr_en;    // Low for x0, illegal or no destination
        xlen_t    data;
        logic     illegal;
    } exe_res_t;

    typedef struct packed {
        stamp_t   stamp;
        delay_t   delay;
        xlen_t    pc;
        reg_idx_t rd;
        logic     wr_en;
        xlen_t    data;
        logic     illegal;
    } trace_rec_t;

endpackage

/* source/rv_decode.sv */
// --------------------
// Instructions arrive in program order on the taken path.
// Only the PC is tracked here, nothing is fetched.
// --------------------

`timescale 1ns/1ps

module rv_decode import rv_core_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  xlen_t   instr,
    output logic    instr_ready,
    output logic    dec_valid,
    output dec_op_t dec,
    input  logic    dec_ready
);

    xlen_t   pc_q;
    dec_op_t dec_d;
    xlen_t   imm_j;
    logic    accept;

    assign instr_ready = ~dec_valid | dec_ready;
    assign accept      = instr_valid & instr_ready;
    assign imm_j       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic       bad_rd;
        logic       bad_rs1;
        logic       bad_rs2;

        opcode  = instr[6:0];
        funct3  = instr[14:12];
        funct7  = instr[31:25];
        bad_rd  = int'(instr[11:7]) >= NUM_REGS;
        bad_rs1 = int'(instr[19:15]) >= NUM_REGS;
        bad_rs2 = int'(instr[24:20]) >= NUM_REGS;

        dec_d         = '0;
        dec_d.pc      = pc_q;
        dec_d.alu_op  = ALU_ADD;
        dec_d.rd      = instr[11:7];
        dec_d.illegal = 1'b1;  // Cleared by a recognised encoding

        case (opcode)
            OPC_OP: begin
                dec_d.rs1     = instr[19:15];
                dec_d.rs2     = instr[24:20];
                dec_d.illegal = bad_rd | bad_rs1 | bad_rs2;
                case (funct3)
                    F3_ADD: begin
                        if (funct7 == F7_SUB) dec_d.alu_op = ALU_SUB;
                        else if (funct7 != F7_BASE) dec_d.illegal = 1'b1;
                    end
                    F3_XOR: dec_d.alu_op = ALU_XOR;
                    F3_OR:  dec_d.alu_op = ALU_OR;
                    F3_AND: dec_d.alu_op = ALU_AND;
                    default: dec_d.illegal = 1'b1;
                endcase
                if (funct3 != F3_ADD && funct7 != F7_BASE) dec_d.illegal = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_d.rs1     = instr[19:15];
                dec_d.imm     = {{20{instr[31]}}, instr[31:20]};
                dec_d.use_imm = 1'b1;
                dec_d.illegal = bad_rd | bad_rs1;
                case (funct3)
                    F3_ADD: dec_d.alu_op = ALU_ADD;
                    F3_XOR: dec_d.alu_op = ALU_XOR;
                    F3_OR:  dec_d.alu_op = ALU_OR;
                    F3_AND: dec_d.alu_op = ALU_AND;
                    default: dec_d.illegal = 1'b1;  // SLTI, shifts and the rest
                endcase
            end
            OPC_LUI: begin
                dec_d.alu_op  = ALU_PASS_B;
                dec_d.imm     = {instr[31:12], 12'b0};
                dec_d.use_imm = 1'b1;
                dec_d.illegal = bad_rd;
            end
            OPC_JAL: begin
                dec_d.alu_op  = ALU_LINK;
                dec_d.imm     = imm_j;
                dec_d.illegal = bad_rd;
            end
            default: ;
        endcase

        dec_d.wr_en = ~dec_d.illegal;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            pc_q      <= RESET_PC;
        end else begin
            if (accept) begin
                dec_valid <= 1'b1;
                // Taken jump redirects the traced PC
                if (dec_d.alu_op == ALU_LINK && !dec_d.illegal) pc_q <= pc_q + imm_j;
                else pc_q <= pc_q + 32'd4;
            end else if (dec_ready) begin
                dec_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) dec <= dec_d;
    end

endmodule

/* source/rv_execute.sv */
// --------------------
// Holds one decoded op. Operands are read while it waits, so the
// producer is always in the result stage or already in the regfile.
// --------------------

`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     dec_valid,
    input  dec_op_t  dec,
    output logic     dec_ready,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    input  logic     fwd_valid,
    input  reg_idx_t fwd_idx,
    input  xlen_t    fwd_data,
    output logic     exe_valid,
    output exe_res_t exe,
    input  logic     exe_ready
);

    dec_op_t op_q;
    xlen_t   op_a;
    xlen_t   op_b;
    xlen_t   alu_out;
    logic    wr_en;

    assign dec_ready = ~exe_valid | exe_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else if (dec_ready) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) op_q <= dec;
    end

    // --------------------
    // Operands
    // --------------------
    assign rs1_idx = op_q.rs1;
    assign rs2_idx = op_q.rs2;

    // Pending write in the result stage wins over the regfile
    assign op_a = (fwd_valid && fwd_idx == op_q.rs1 && op_q.rs1 != '0) ? fwd_data : rs1_data;

    always_comb begin
        if (op_q.use_imm) op_b = op_q.imm;
        else if (fwd_valid && fwd_idx == op_q.rs2 && op_q.rs2 != '0) op_b = fwd_data;
        else op_b = rs2_data;
    end

    always_comb begin
        case (op_q.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_PASS_B: alu_out = op_b;
            ALU_LINK:   alu_out = op_q.pc + 32'd4;
            default:    alu_out = '0;
        endcase
    end

    assign wr_en = op_q.wr_en & ~op_q.illegal & (op_q.rd != '0);

    assign exe.pc      = op_q.pc;
    assign exe.rd      = op_q.rd;
    assign exe.wr_en   = wr_en;
    assign exe.data    = wr_en ? alu_out : '0;  // Zero when nothing is written
    assign exe.illegal = op_q.illegal;

endmodule

/* source/rv_regfile.sv */
// --------------------
// Reads are combinational, writes land on the clock edge.
// Indices at or above NUM_REGS read zero and are not written.
// --------------------

`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  xlen_t    wr_data,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output xlen_t    rd_data_a,
    output xlen_t    rd_data_b
);

    xlen_t regs [1:NUM_REGS-1];  // x0 has no storage

    function automatic logic idx_ok(reg_idx_t idx);
        return (idx != '0) && (int'(idx) < NUM_REGS);
    endfunction

    assign rd_data_a = idx_ok(rd_idx_a) ? regs[rd_idx_a] : '0;
    assign rd_data_b = idx_ok(rd_idx_b) ? regs[rd_idx_b] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && idx_ok(wr_idx)) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

/* source/rv_result.sv */
// --------------------
// The regfile write happens on the edge the item moves to the trace
// stage. Until then the write is offered for forwarding.
// --------------------

`timescale 1ns/1ps

module rv_result import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     exe_valid,
    input  exe_res_t exe,
    output logic     exe_ready,
    output logic     fwd_valid,
    output reg_idx_t fwd_idx,
    output xlen_t    fwd_data,
    output logic     rf_wr_en,
    output logic     ret_valid,
    output exe_res_t ret,
    input  logic     ret_ready
);

    logic     res_valid;
    exe_res_t res_q;

    assign exe_ready = ~res_valid | ret_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (exe_ready) begin
            res_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid && exe_ready) res_q <= exe;
    end

    // Pending write, visible to execute
    assign fwd_valid = res_valid & res_q.wr_en;
    assign fwd_idx   = res_q.rd;
    assign fwd_data  = res_q.data;

    // Commit on the retire handshake
    assign rf_wr_en = res_valid & ret_ready & res_q.wr_en;

    assign ret_valid = res_valid;
    assign ret       = res_q;

endmodule

/* source/rv_trace_core.sv */
// --------------------
// Four-stage RV32I core with a retire trace port.
// Trace latency is three cycles after instruction accept.
// --------------------

`timescale 1ns/1ps

module rv_trace_core import rv_core_pkg::*; #(
    parameter int NUM_REGS = 32  // 16 for an RVE-style core
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  xlen_t      instr,
    output logic       instr_ready,
    output logic       trace_valid,
    output trace_rec_t trace,
    input  logic       trace_ready
);

    logic     dec_valid, dec_ready;
    dec_op_t  dec;
    logic     exe_valid, exe_ready;
    exe_res_t exe;
    logic     ret_valid, ret_ready;
    exe_res_t ret;
    reg_idx_t rs1_idx, rs2_idx;
    xlen_t    rs1_data, rs2_data;
    logic     fwd_valid;
    reg_idx_t fwd_idx;
    xlen_t    fwd_data;
    logic     rf_wr_en;

    rv_decode #(.NUM_REGS(NUM_REGS)) decode_i (
        .clk, .rst_n, .instr_valid, .instr, .instr_ready,
        .dec_valid, .dec, .dec_ready
    );

    rv_regfile #(.NUM_REGS(NUM_REGS)) regfile_i (
        .clk, .rst_n,
        .wr_en     (rf_wr_en),
        .wr_idx    (ret.rd),
        .wr_data   (ret.data),
        .rd_idx_a  (rs1_idx),
        .rd_idx_b  (rs2_idx),
        .rd_data_a (rs1_data),
        .rd_data_b (rs2_data)
    );

    rv_execute execute_i (
        .clk, .rst_n, .dec_valid, .dec, .dec_ready,
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .fwd_valid, .fwd_idx, .fwd_data,
        .exe_valid, .exe, .exe_ready
    );

    rv_result result_i (
        .clk, .rst_n, .exe_valid, .exe, .exe_ready,
        .fwd_valid, .fwd_idx, .fwd_data, .rf_wr_en,
        .ret_valid, .ret, .ret_ready
    );

    rv_tracelog tracelog_i (
        .clk, .rst_n, .ret_valid, .ret, .ret_ready,
        .trace_valid, .trace, .trace_ready
    );

endmodule

/* source/rv_tracelog.sv */
// --------------------
// The stamp counter wraps after 2^32 cycles. The delay saturates at
// 16 bits. The first record's delay equals its stamp.
// --------------------

`timescale 1ns/1ps

module rv_tracelog import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ret_valid,
    input  exe_res_t   ret,
    output logic       ret_ready,
    output logic       trace_valid,
    output trace_rec_t trace,
    input  logic       trace_ready
);

    stamp_t     cycle_cnt;
    stamp_t     last_stamp;
    stamp_t     diff;
    delay_t     delay;
    trace_rec_t rec_d;
    logic       load;

    // --------------------
    // Cycle counter
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) cycle_cnt <= '0;
        else cycle_cnt <= cycle_cnt + 1'b1;
    end

    assign diff  = cycle_cnt - last_stamp;
    assign delay = (diff[31:16] != '0) ? '1 : diff[15:0];  // Saturate

    // --------------------
    // Record build
    // --------------------
    always_comb begin
        rec_d.stamp   = cycle_cnt;
        rec_d.delay   = delay;
        rec_d.pc      = ret.pc;
        rec_d.rd      = ret.rd;
        rec_d.wr_en   = ret.wr_en;
        rec_d.data    = ret.data;
        rec_d.illegal = ret.illegal;
    end

    assign ret_ready = ~trace_valid | trace_ready;
    assign load      = ret_valid & ret_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trace_valid <= 1'b0;
            last_stamp  <= '0;
        end else begin
            if (ret_ready) trace_valid <= ret_valid;
            if (load) last_stamp <= cycle_cnt;
        end
    end

    // Output register, held while trace_ready is low
    always_ff @(posedge clk) begin
        if (load) trace <= rec_d;
    end

endmodule

/* test/core_tests.txt */
// Columns: test number, instruction, then expected record pc, rd, wr_en, data, illegal
// All values hex, one instruction per line in program order
01 00500093 00000000 01 1 00000005 0
02 00308113 00000004 02 1 00000008 0
03 002081b3 00000008 03 1 0000000d 0
04 40118233 0000000c 04 1 00000008 0
05 0ff24293 00000010 05 1 000000f7 0
06 0032f333 00000014 06 1 00000005 0
07 004363b3 00000018 07 1 0000000d 0
08 0013c433 0000001c 08 1 00000008 0
09 ff02f493 00000020 09 1 000000f0 0
0a fff06513 00000024 0a 1 ffffffff 0
0b 123455b7 00000028 0b 1 12345000 0
0c 67858593 0000002c 0b 1 12345678 0
0d 00708013 00000030 00 0 00000000 0
0e 00100633 00000034 0c 1 00000005 0
0f 00000000 00000038 00 0 00000000 1
10 0010a693 0000003c 0d 0 00000000 1
11 010000ef 00000040 01 1 00000044 0
12 002086b3 00000050 0d 1 0000004c 0
13 ff9ff06f 00000054 00 0 00000000 0
14 40b68733 0000004c 0e 1 edcba9d4 0
15 00a747b3 00000050 0f 1 1234562b 0

/* test/tb_rv_trace_core.sv */
// --------------------
// Reads test/core_tests.txt relative to the run directory.
// Test numbers in the first column must count up from 1 without gaps.
// Stops at the first mismatch.
// --------------------

`timescale 1ns/1ps

module tb_rv_trace_core import rv_core_pkg::*; ();

    localparam int MAX_TESTS = 64;
    localparam int COLS      = 7;   // num, instr, pc, rd, wr_en, data, illegal
    localparam int NUM_REGS  = 32;

    logic       clk;
    logic       rst_n;
    logic       instr_valid;
    xlen_t      instr;
    logic       instr_ready;
    logic       trace_valid;
    trace_rec_t trace;
    logic       trace_ready;

    logic [31:0] vec_mem [0:MAX_TESTS*COLS-1];
    int          num_tests;
    int          rec_count;
    logic        loaded = 1'b0;
    logic [15:0] lfsr_state;

    rv_trace_core #(.NUM_REGS(NUM_REGS)) dut_i (
        .clk, .rst_n, .instr_valid, .instr, .instr_ready,
        .trace_valid, .trace, .trace_ready
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois, taps 16 14 13 11
    endfunction

    task automatic draw_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
        else stop_with_failure($sformatf("CHECK FAILED: %s is 0x%h, expected 0x%h",
                                         name, got, exp));
    endtask

    task automatic check_record(input int n, input stamp_t exp_stamp,
                                input stamp_t prev_stamp);
        int          base;
        logic [31:0] exp_delay;

        base = n * COLS;
        compare_field("trace.pc", trace.pc, vec_mem[base+2]);
        compare_field("trace.rd", 32'(trace.rd), vec_mem[base+3]);
        compare_field("trace.wr_en", 32'(trace.wr_en), vec_mem[base+4]);
        compare_field("trace.data", trace.data, vec_mem[base+5]);
        compare_field("trace.illegal", 32'(trace.illegal), vec_mem[base+6]);
        compare_field("trace.stamp", trace.stamp, exp_stamp);

        if (n == 0) begin
            exp_delay = exp_stamp;  // First record counts from reset
        end else begin
            exp_delay = exp_stamp - prev_stamp;
        end
        if (exp_delay > 32'h0000_ffff) exp_delay = 32'h0000_ffff;  // Saturates
        compare_field("trace.delay", 32'(trace.delay), exp_delay);
    endtask

    // Watchdog, armed once the test count is known
    initial begin
        wait (loaded);
        repeat (40 * num_tests + 100) @(posedge clk);
        stop_with_failure($sformatf("Timeout: %0d of %0d trace records arrived",
                                    rec_count, num_tests));
    end

    // --------------------
    // Stimulus and checks
    // --------------------
    initial begin
        int     next_idx;
        int     cycle_num;
        logic   b0;
        logic   b1;
        logic   accepted;
        logic   rec_held;
        stamp_t exp_stamp;
        stamp_t prev_stamp;

        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        trace_ready = 1'b0;
        lfsr_state  = 16'd66;
        rec_count   = 0;
        num_tests   = 0;
        next_idx    = 0;
        cycle_num   = 0;
        rec_held    = 1'b0;
        exp_stamp   = '0;
        prev_stamp  = '0;

        for (int i = 0; i < MAX_TESTS * COLS; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("test/core_tests.txt", vec_mem);
        while (num_tests < MAX_TESTS && vec_mem[num_tests*COLS] == 32'(num_tests + 1)) begin
            num_tests++;
        end
        if (num_tests == 0) stop_with_failure("No tests found in test/core_tests.txt");
        loaded = 1'b1;

        // Trace port stays quiet during reset
        repeat (4) begin
            @(negedge clk);
            assert (trace_valid === 1'b0)
            else stop_with_failure($sformatf("CHECK FAILED: trace_valid is 0x%h during reset",
                                             trace_valid));
        end
        rst_n = 1'b1;

        while (rec_count < num_tests) begin
            if (!instr_valid && next_idx < num_tests) begin
                draw_bit(b0);
                draw_bit(b1);
                if (!(b0 & b1)) begin  // Gap in one cycle of four
                    instr_valid = 1'b1;
                    instr       = vec_mem[next_idx*COLS+1];
                end
            end
            draw_bit(b0);
            draw_bit(b1);
            trace_ready = b0 | b1;

            // Settled values decide the transfers on the next rising edge
            #1;
            // A record not held over was loaded at the last edge
            if (trace_valid && !rec_held) exp_stamp = stamp_t'(cycle_num - 1);
            if (trace_valid && trace_ready) begin
                check_record(rec_count, exp_stamp, prev_stamp);
                prev_stamp = exp_stamp;
                rec_count++;
            end
            rec_held = trace_valid & ~trace_ready;
            accepted = instr_valid & instr_ready;

            @(negedge clk);
            cycle_num++;  // Rising edges since reset release
            if (accepted) begin
                instr_valid = 1'b0;
                instr       = '0;
                next_idx++;
            end
        end

        // Nothing more may come out
        trace_ready = 1'b1;
        repeat (10) begin
            #1;
            if (trace_valid) rec_count++;
            @(negedge clk);
        end

        if (rec_count == num_tests) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("Extra trace records: %0d received, %0d expected",
                                        rec_count, num_tests));
        end
    end

endmodule
